// File: files.f
hw/rv_ctrl_pkg.sv
hw/main_decoder.sv
hw/alu_decoder.sv
hw/branch_resolver.sv
hw/stage_controller.sv
hw/hazard_unit.sv
hw/pipeline_control.sv
bench/pipeline_control_sva.sv
bench/pipeline_control_tb.sv

// File: bench/pipeline_control_tb.sv
`timescale 1ns/1ps

module pipeline_control_tb import rv_ctrl_pkg::*; ();

  localparam int CLK_PERIOD = 10;
  // reset, decode, branch, forwarding, load-use and flush cycles
  localparam int TEST_CYCLES = 17 + 13 * 4 + 50 * 2 + 7 * 4 + 16 + 12;

  logic        clk = 1'b0;
  logic        i_rst;
  logic [31:0] i_inst_d;
  logic        i_zero_e;
  logic        i_neg_e;
  logic        i_negu_e;
  imm_src_t    o_imm_src_d;
  logic        o_jal_d;
  logic        o_ecall_d;
  alu_ctrl_t   o_alu_ctrl_e;
  logic        o_alu_src_e;
  logic        o_imm_plus_src_e;
  pc_src_t     o_pc_src_e;
  result_src_t o_result_src_e;
  logic [4:0]  o_rd_e;
  logic [4:0]  o_rs1_e;
  logic [4:0]  o_rs2_e;
  logic        o_mem_req_m;
  logic        o_mem_write_m;
  mem_size_t   o_mem_size_m;
  logic        o_is_load_signed_m;
  result_src_t o_result_src_m;
  logic        o_reg_write_m;
  logic [4:0]  o_rd_m;
  result_src_t o_result_src_w;
  logic        o_reg_write_w;
  logic [4:0]  o_rd_w;
  fwd_t        o_fwd_a_e;
  fwd_t        o_fwd_b_e;
  logic        o_stall_f;
  logic        o_stall_d;
  logic        o_flush_d;

  int n_tests;
  int n_checks;
  int n_errors;
  int test_errors;

  pipeline_control UUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // expected value below zero means not checked
  task automatic check(input string name, input int exp, input logic [31:0] act);
    if (exp >= 0) begin
      n_checks++;
      assert (act === 32'(exp)) else begin
        n_errors++;
        test_errors++;
        $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
      end
    end
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("test %-10s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // add when it writes a register, store otherwise
  function automatic logic [31:0] producer(input logic [4:0] rd, input bit wr);
    return wr ? enc(7'h00, 5'd0, 5'd0, 3'b000, rd, OP_OP)
              : enc(7'h00, 5'd0, 5'd0, 3'b010, rd, OP_STORE);
  endfunction

  // flags packed as {zero, neg, negu}
  function automatic bit taken(input logic [2:0] f3, input logic [2:0] fl);
    case (f3)
      3'b000:  return fl[2];
      3'b001:  return !fl[2];
      3'b100:  return fl[1];
      3'b101:  return !fl[1];
      3'b110:  return fl[0];
      3'b111:  return !fl[0];
      default: return 1'b0;
    endcase
  endfunction

  task automatic reset_test();
    @(negedge clk);
    check("o_reg_write_m", 0, o_reg_write_m);
    check("o_mem_req_m", 0, o_mem_req_m);
    check("o_mem_write_m", 0, o_mem_write_m);
    check("o_reg_write_w", 0, o_reg_write_w);
    check("o_pc_src_e", PC_PLUS4, o_pc_src_e);
    check("o_stall_f", 0, o_stall_f);
    check("o_stall_d", 0, o_stall_d);
    check("o_flush_d", 0, o_flush_d);
    finish_test("reset");
  endtask

  // one instruction followed by nops, checked in every stage
  task automatic stage_class(input string name, input logic [31:0] inst,
                             input int rw, input int mreq, input int mwr, input int res,
                             input int asrc, input int imm, input int actrl, input int iplus,
                             input int jal, input int ecall, input int pcs,
                             input int msize, input int lsigned);
    logic [31:0] word;
    logic [4:0]  rd;
    word = inst;
    if (inst[6:0] != OP_SYSTEM) begin
      word[11:7] = 5'($urandom_range(31, 1));
    end
    rd = word[11:7];
    next_cycle();
    i_inst_d = word;
    @(negedge clk);
    check({name, ": o_imm_src_d"}, imm, o_imm_src_d);
    check({name, ": o_jal_d"}, jal, o_jal_d);
    check({name, ": o_ecall_d"}, ecall, o_ecall_d);
    next_cycle();
    i_inst_d = '0;
    @(negedge clk);
    check({name, ": o_alu_ctrl_e"}, actrl, o_alu_ctrl_e);
    check({name, ": o_alu_src_e"}, asrc, o_alu_src_e);
    check({name, ": o_imm_plus_src_e"}, iplus, o_imm_plus_src_e);
    check({name, ": o_result_src_e"}, res, o_result_src_e);
    check({name, ": o_rd_e"}, rd, o_rd_e);
    check({name, ": o_pc_src_e"}, pcs, o_pc_src_e);
    next_cycle();
    @(negedge clk);
    check({name, ": o_mem_req_m"}, mreq, o_mem_req_m);
    check({name, ": o_mem_write_m"}, mwr, o_mem_write_m);
    check({name, ": o_mem_size_m"}, msize, o_mem_size_m);
    check({name, ": o_is_load_signed_m"}, lsigned, o_is_load_signed_m);
    check({name, ": o_result_src_m"}, res, o_result_src_m);
    check({name, ": o_reg_write_m"}, rw, o_reg_write_m);
    check({name, ": o_rd_m"}, rd, o_rd_m);
    next_cycle();
    @(negedge clk);
    check({name, ": o_result_src_w"}, res, o_result_src_w);
    check({name, ": o_reg_write_w"}, rw, o_reg_write_w);
    check({name, ": o_rd_w"}, rd, o_rd_w);
  endtask

  task automatic decode_test();
    stage_class("sub", enc(7'h20, 5'd3, 5'd2, 3'b000, 5'd0, OP_OP),
                1, 0, 0, RES_ALU, 0, -1, ALU_SUB, -1, 0, 0, PC_PLUS4, -1, -1);
    stage_class("srai", enc(7'h20, 5'd4, 5'd1, 3'b101, 5'd0, OP_OPIMM),
                1, 0, 0, RES_ALU, 1, IMM_I, ALU_SRA, -1, 0, 0, PC_PLUS4, -1, -1);
    // bit 30 of the immediate must not turn addi into sub
    stage_class("addi", enc(7'h20, 5'd7, 5'd1, 3'b000, 5'd0, OP_OPIMM),
                1, 0, 0, RES_ALU, 1, IMM_I, ALU_ADD, -1, 0, 0, PC_PLUS4, -1, -1);
    stage_class("lb", enc(7'h00, 5'd0, 5'd1, 3'b000, 5'd0, OP_LOAD),
                1, 1, 0, RES_MEM, 1, IMM_I, ALU_ADD, -1, 0, 0, PC_PLUS4, SIZE_B, 1);
    stage_class("lhu", enc(7'h00, 5'd0, 5'd1, 3'b101, 5'd0, OP_LOAD),
                1, 1, 0, RES_MEM, 1, IMM_I, ALU_ADD, -1, 0, 0, PC_PLUS4, SIZE_H, 0);
    stage_class("sw", enc(7'h00, 5'd5, 5'd1, 3'b010, 5'd0, OP_STORE),
                0, 1, 1, -1, 1, IMM_S, ALU_ADD, -1, 0, 0, PC_PLUS4, SIZE_W, -1);
    stage_class("beq", enc(7'h00, 5'd5, 5'd1, 3'b000, 5'd0, OP_BRANCH),
                0, 0, 0, -1, 0, IMM_B, ALU_SUB, -1, 0, 0, PC_PLUS4, -1, -1);
    stage_class("jal", enc(7'h15, 5'd9, 5'd3, 3'b010, 5'd0, OP_JAL),
                1, 0, 0, RES_PC4, 0, IMM_J, -1, 0, 1, 0, PC_PLUS4, -1, -1);
    stage_class("jalr", enc(7'h00, 5'd8, 5'd1, 3'b000, 5'd0, OP_JALR),
                1, 0, 0, RES_PC4, 1, IMM_I, ALU_ADD, 1, 0, 0, PC_JALR, -1, -1);
    stage_class("lui", enc(7'h12, 5'd6, 5'd2, 3'b011, 5'd0, OP_LUI),
                1, 0, 0, RES_ALU, 1, IMM_U, ALU_PASSB, -1, 0, 0, PC_PLUS4, -1, -1);
    stage_class("auipc", enc(7'h12, 5'd6, 5'd2, 3'b011, 5'd0, OP_AUIPC),
                1, 0, 0, RES_ALU, 1, IMM_U, -1, 1, 0, 0, PC_PLUS4, -1, -1);
    stage_class("ecall", 32'h0000_0073,
                0, 0, 0, -1, -1, -1, -1, -1, 0, 1, PC_ECALL, -1, -1);
    // unknown opcode is a bubble
    stage_class("unknown", enc(7'h00, 5'd1, 5'd1, 3'b000, 5'd0, 7'b1111111),
                0, 0, 0, -1, -1, -1, -1, -1, 0, 0, PC_PLUS4, -1, -1);
    finish_test("decode");
  endtask

  task automatic resolve_case(input logic [31:0] inst, input logic [2:0] fl, input int exp_pc);
    next_cycle();
    i_inst_d = inst;
    next_cycle();
    i_inst_d = '0;
    {i_zero_e, i_neg_e, i_negu_e} = fl;
    @(negedge clk);
    check("o_pc_src_e", exp_pc, o_pc_src_e);
    check("o_flush_d", int'(exp_pc != PC_PLUS4), o_flush_d);
  endtask

  task automatic branch_test();
    logic [31:0] inst;
    int f3;
    int fl;
    for (f3 = 0; f3 < 8; f3++) begin
      if (f3 != 2 && f3 != 3) begin
        for (fl = 0; fl < 8; fl++) begin
          inst = enc(7'h00, 5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)),
                     3'(f3), 5'd0, OP_BRANCH);
          resolve_case(inst, 3'(fl), taken(3'(f3), 3'(fl)) ? PC_BRANCH : PC_PLUS4);
        end
      end
    end
    // flags must not matter for jalr and ecall
    resolve_case(enc(7'h00, 5'd0, 5'd1, 3'b000, 5'd1, OP_JALR), 3'($urandom), PC_JALR);
    resolve_case(32'h0000_0073, 3'($urandom), PC_ECALL);
    {i_zero_e, i_neg_e, i_negu_e} = 3'b000;
    finish_test("branch");
  endtask

  // consumer in execute, second producer in memory, first in writeback
  task automatic fwd_case(input logic [4:0] rd1, input bit wr1, input logic [4:0] rd2,
                          input bit wr2, input logic [4:0] rs1, input logic [4:0] rs2,
                          input int exp_a, input int exp_b);
    next_cycle();
    i_inst_d = producer(rd1, wr1);
    next_cycle();
    i_inst_d = producer(rd2, wr2);
    next_cycle();
    i_inst_d = enc(7'h00, rs2, rs1, 3'b000, 5'd1, OP_OP);
    next_cycle();
    i_inst_d = '0;
    @(negedge clk);
    check("o_rs1_e", rs1, o_rs1_e);
    check("o_rs2_e", rs2, o_rs2_e);
    check("o_fwd_a_e", exp_a, o_fwd_a_e);
    check("o_fwd_b_e", exp_b, o_fwd_b_e);
  endtask

  task automatic forward_test();
    fwd_case(5'd5, 1, 5'd6, 1, 5'd6, 5'd5, FWD_MEM, FWD_WB);
    fwd_case(5'd7, 1, 5'd7, 1, 5'd7, 5'd3, FWD_MEM, FWD_NONE);
    fwd_case(5'd0, 1, 5'd0, 1, 5'd0, 5'd0, FWD_NONE, FWD_NONE);
    fwd_case(5'd9, 1, 5'd9, 0, 5'd9, 5'd9, FWD_WB, FWD_WB);
    fwd_case(5'd4, 0, 5'd4, 0, 5'd4, 5'd4, FWD_NONE, FWD_NONE);
    fwd_case(5'd12, 1, 5'd13, 1, 5'd13, 5'd13, FWD_MEM, FWD_MEM);
    fwd_case(5'd0, 1, 5'd8, 1, 5'd2, 5'd3, FWD_NONE, FWD_NONE);
    finish_test("forward");
  endtask

  task automatic load_use_case(input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [4:0] rs2, input bit exp_stall);
    next_cycle();
    i_inst_d = enc(7'h00, 5'd0, 5'd1, 3'b010, rd, OP_LOAD);
    next_cycle();
    i_inst_d = enc(7'h00, rs2, rs1, 3'b000, 5'd10, OP_OP);
    @(negedge clk);
    check("o_stall_f", exp_stall, o_stall_f);
    check("o_stall_d", exp_stall, o_stall_d);
    check("o_flush_d", 0, o_flush_d);
    if (exp_stall) begin
      // consumer stays in decode, execute gets a bubble
      next_cycle();
      @(negedge clk);
      check("o_result_src_e", RES_ALU, o_result_src_e);
      check("o_stall_d", 0, o_stall_d);
      check("o_result_src_m", RES_MEM, o_result_src_m);
      check("o_reg_write_m", 1, o_reg_write_m);
      next_cycle();
      i_inst_d = '0;
      @(negedge clk);
      check("o_reg_write_m", 0, o_reg_write_m);
      check("o_rd_e", 10, o_rd_e);
      check("o_fwd_a_e", (rs1 == rd) ? FWD_WB : FWD_NONE, o_fwd_a_e);
      check("o_fwd_b_e", (rs2 == rd) ? FWD_WB : FWD_NONE, o_fwd_b_e);
    end
    next_cycle();
    i_inst_d = '0;
  endtask

  task automatic load_use_test();
    load_use_case(5'd8, 5'd8, 5'd2, 1);
    load_use_case(5'd8, 5'd3, 5'd8, 1);
    load_use_case(5'd0, 5'd0, 5'd0, 0);
    load_use_case(5'd8, 5'd3, 5'd4, 0);
    finish_test("load_use");
  endtask

  // the instruction in decode behind the redirect must vanish
  task automatic flush_case(input logic [31:0] inst, input logic [31:0] victim,
                            input logic [2:0] fl);
    next_cycle();
    i_inst_d = inst;
    next_cycle();
    i_inst_d = victim;
    {i_zero_e, i_neg_e, i_negu_e} = fl;
    @(negedge clk);
    check("o_flush_d", 1, o_flush_d);
    next_cycle();
    i_inst_d = '0;
    {i_zero_e, i_neg_e, i_negu_e} = 3'b000;
    @(negedge clk);
    check("o_alu_src_e", 0, o_alu_src_e);
    check("o_imm_plus_src_e", 0, o_imm_plus_src_e);
    check("o_result_src_e", RES_ALU, o_result_src_e);
    check("o_pc_src_e", PC_PLUS4, o_pc_src_e);
    check("o_flush_d", 0, o_flush_d);
    next_cycle();
    @(negedge clk);
    check("o_reg_write_m", 0, o_reg_write_m);
    check("o_mem_req_m", 0, o_mem_req_m);
    check("o_mem_write_m", 0, o_mem_write_m);
  endtask

  task automatic flush_test();
    // victims differ so that every bubble check would see a leak
    flush_case(enc(7'h00, 5'd5, 5'd1, 3'b000, 5'd0, OP_BRANCH),
               enc(7'h00, 5'd0, 5'd2, 3'b000, 5'd11, OP_JALR), 3'b100);
    flush_case(enc(7'h00, 5'd5, 5'd1, 3'b110, 5'd0, OP_BRANCH),
               enc(7'h00, 5'd2, 5'd1, 3'b010, 5'd11, OP_STORE), 3'b001);
    flush_case(enc(7'h00, 5'd0, 5'd1, 3'b000, 5'd1, OP_JALR),
               enc(7'h00, 5'd0, 5'd1, 3'b010, 5'd11, OP_LOAD), 3'b000);
    finish_test("flush");
  endtask

  initial begin
    void'($urandom(32'h76dd_665c));
    n_tests = 0;
    n_checks = 0;
    n_errors = 0;
    test_errors = 0;
    i_rst = 1'b1;
    i_inst_d = '0;
    i_zero_e = 1'b0;
    i_neg_e = 1'b0;
    i_negu_e = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    i_rst = 1'b0;
    reset_test();
    decode_test();
    branch_test();
    forward_test();
    load_use_test();
    flush_test();
    next_cycle();
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // twice the expected run length
  initial begin
    #(TEST_CYCLES * CLK_PERIOD * 2);
    $display("watchdog expired at %0t, the tests did not finish", $time);
    $display("Something failed");
    $finish;
  end

endmodule

// File: bench/pipeline_control_sva.sv
`timescale 1ns/1ps

module pipeline_control_sva (
  input logic clk,
  input logic i_rst,
  input logic i_stall_f,
  input logic i_stall_d,
  input logic i_flush_d,
  input logic i_id_ex_clear
);

  // fetch and decode always stall together
  stall_pair: assert property (@(posedge clk) disable iff (i_rst) i_stall_f == i_stall_d)
    else $error("fetch stall and decode stall differ");

  // any stall or flush must empty id/ex
  clear_on_hazard: assert property (@(posedge clk) disable iff (i_rst)
    (i_stall_d || i_flush_d) |-> i_id_ex_clear)
    else $error("stall or flush without id/ex clear");

  // pipeline is empty right after reset
  quiet_after_reset: assert property (@(posedge clk)
    $fell(i_rst) |-> !(i_stall_f || i_stall_d || i_flush_d))
    else $error("stall or flush in the first cycle after reset");

endmodule

// hazard unit has no clock, so attach at its parent where clk is visible
bind pipeline_control pipeline_control_sva u_sva (
  .clk           (clk),
  .i_rst         (i_rst),
  .i_stall_f     (o_stall_f),
  .i_stall_d     (o_stall_d),
  .i_flush_d     (o_flush_d),
  .i_id_ex_clear (id_ex_clear)
);

// File: hw/pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control import rv_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        i_rst,
  input  logic [31:0] i_inst_d,
  input  logic        i_zero_e,
  input  logic        i_neg_e,
  input  logic        i_negu_e,
  // decode
  output imm_src_t    o_imm_src_d,
  output logic        o_jal_d,
  output logic        o_ecall_d,
  // execute
  output alu_ctrl_t   o_alu_ctrl_e,
  output logic        o_alu_src_e,
  output logic        o_imm_plus_src_e,
  output pc_src_t     o_pc_src_e,
  output result_src_t o_result_src_e,
  output logic [4:0]  o_rd_e,
  output logic [4:0]  o_rs1_e,
  output logic [4:0]  o_rs2_e,
  // memory
  output logic        o_mem_req_m,
  output logic        o_mem_write_m,
  output mem_size_t   o_mem_size_m,
  output logic        o_is_load_signed_m,
  output result_src_t o_result_src_m,
  output logic        o_reg_write_m,
  output logic [4:0]  o_rd_m,
  // writeback
  output result_src_t o_result_src_w,
  output logic        o_reg_write_w,
  output logic [4:0]  o_rd_w,
  // hazards
  output fwd_t        o_fwd_a_e,
  output fwd_t        o_fwd_b_e,
  output logic        o_stall_f,
  output logic        o_stall_d,
  output logic        o_flush_d
);

  logic       id_ex_clear;
  logic [4:0] rs1_d;
  logic [4:0] rs2_d;

  // source registers of the instruction in decode, for load-use
  assign rs1_d = i_inst_d[19:15];
  assign rs2_d = i_inst_d[24:20];

  stage_controller u_stage_controller (
    .clk                (clk),
    .i_rst              (i_rst),
    .i_inst_d           (i_inst_d),
    .i_id_ex_clear      (id_ex_clear),
    .i_zero_e           (i_zero_e),
    .i_neg_e            (i_neg_e),
    .i_negu_e           (i_negu_e),
    .o_imm_src_d        (o_imm_src_d),
    .o_jal_d            (o_jal_d),
    .o_ecall_d          (o_ecall_d),
    .o_alu_ctrl_e       (o_alu_ctrl_e),
    .o_alu_src_e        (o_alu_src_e),
    .o_imm_plus_src_e   (o_imm_plus_src_e),
    .o_pc_src_e         (o_pc_src_e),
    .o_result_src_e     (o_result_src_e),
    .o_rd_e             (o_rd_e),
    .o_rs1_e            (o_rs1_e),
    .o_rs2_e            (o_rs2_e),
    .o_mem_req_m        (o_mem_req_m),
    .o_mem_write_m      (o_mem_write_m),
    .o_mem_size_m       (o_mem_size_m),
    .o_is_load_signed_m (o_is_load_signed_m),
    .o_result_src_m     (o_result_src_m),
    .o_reg_write_m      (o_reg_write_m),
    .o_rd_m             (o_rd_m),
    .o_result_src_w     (o_result_src_w),
    .o_reg_write_w      (o_reg_write_w),
    .o_rd_w             (o_rd_w)
  );

  hazard_unit u_hazard_unit (
    .i_rs1_d        (rs1_d),
    .i_rs2_d        (rs2_d),
    .i_rs1_e        (o_rs1_e),
    .i_rs2_e        (o_rs2_e),
    .i_rd_e         (o_rd_e),
    .i_rd_m         (o_rd_m),
    .i_rd_w         (o_rd_w),
    .i_result_src_e (o_result_src_e),
    .i_reg_write_m  (o_reg_write_m),
    .i_reg_write_w  (o_reg_write_w),
    .i_pc_src_e     (o_pc_src_e),
    .o_fwd_a_e      (o_fwd_a_e),
    .o_fwd_b_e      (o_fwd_b_e),
    .o_stall_f      (o_stall_f),
    .o_stall_d      (o_stall_d),
    .o_flush_d      (o_flush_d),
    .o_id_ex_clear  (id_ex_clear)
  );

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv_ctrl_pkg::*; (
  input  logic [4:0]  i_rs1_d,
  input  logic [4:0]  i_rs2_d,
  input  logic [4:0]  i_rs1_e,
  input  logic [4:0]  i_rs2_e,
  input  logic [4:0]  i_rd_e,
  input  logic [4:0]  i_rd_m,
  input  logic [4:0]  i_rd_w,
  input  result_src_t i_result_src_e,
  input  logic        i_reg_write_m,
  input  logic        i_reg_write_w,
  input  pc_src_t     i_pc_src_e,
  output fwd_t        o_fwd_a_e,
  output fwd_t        o_fwd_b_e,
  output logic        o_stall_f,
  output logic        o_stall_d,
  output logic        o_flush_d,
  output logic        o_id_ex_clear
);

  logic load_use;
  logic redirect;

  // newest producer first, x0 never forwards
  function automatic fwd_t fwd_sel(
    input logic [4:0] rs,
    input logic [4:0] rd_m,
    input logic       wr_m,
    input logic [4:0] rd_w,
    input logic       wr_w
  );
    fwd_t sel;
    if (wr_m && (rd_m != 5'd0) && (rd_m == rs)) begin
      sel = FWD_MEM;
    end else if (wr_w && (rd_w != 5'd0) && (rd_w == rs)) begin
      sel = FWD_WB;
    end else begin
      sel = FWD_NONE;
    end
    return sel;
  endfunction

  assign o_fwd_a_e = fwd_sel(i_rs1_e, i_rd_m, i_reg_write_m, i_rd_w, i_reg_write_w);
  assign o_fwd_b_e = fwd_sel(i_rs2_e, i_rd_m, i_reg_write_m, i_rd_w, i_reg_write_w);

  // load result not ready until writeback, rs fields compared regardless of format
  assign load_use = (i_result_src_e == RES_MEM) && (i_rd_e != 5'd0)
                    && ((i_rd_e == i_rs1_d) || (i_rd_e == i_rs2_d));

  assign redirect = (i_pc_src_e != PC_PLUS4);

  assign o_stall_f     = load_use;
  assign o_stall_d     = load_use;
  assign o_flush_d     = redirect;
  assign o_id_ex_clear = load_use || redirect;

endmodule

// File: hw/stage_controller.sv
`timescale 1ns/1ps

module stage_controller import rv_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        i_rst,
  input  logic [31:0] i_inst_d,
  input  logic        i_id_ex_clear,
  input  logic        i_zero_e,
  input  logic        i_neg_e,
  input  logic        i_negu_e,
  // decode
  output imm_src_t    o_imm_src_d,
  output logic        o_jal_d,
  output logic        o_ecall_d,
  // execute
  output alu_ctrl_t   o_alu_ctrl_e,
  output logic        o_alu_src_e,
  output logic        o_imm_plus_src_e,
  output pc_src_t     o_pc_src_e,
  output result_src_t o_result_src_e,
  output logic [4:0]  o_rd_e,
  output logic [4:0]  o_rs1_e,
  output logic [4:0]  o_rs2_e,
  // memory
  output logic        o_mem_req_m,
  output logic        o_mem_write_m,
  output mem_size_t   o_mem_size_m,
  output logic        o_is_load_signed_m,
  output result_src_t o_result_src_m,
  output logic        o_reg_write_m,
  output logic [4:0]  o_rd_m,
  // writeback
  output result_src_t o_result_src_w,
  output logic        o_reg_write_w,
  output logic [4:0]  o_rd_w
);

  logic [6:0]  opcode_d;
  logic [2:0]  funct3_d;
  logic        reg_write_d, mem_req_d, mem_write_d;
  logic        alu_src_d, imm_plus_src_d, is_load_signed_d;
  logic        branch_d, jalr_d;
  result_src_t result_src_d;
  alu_op_t     alu_op_d;
  alu_ctrl_t   alu_dec_ctrl_d;
  alu_ctrl_t   alu_ctrl_d;
  mem_size_t   mem_size_d;

  logic        reg_write_e, mem_req_e, mem_write_e, is_load_signed_e;
  logic        branch_e, jalr_e, ecall_e;
  logic [2:0]  funct3_e;
  mem_size_t   mem_size_e;

  assign opcode_d = i_inst_d[6:0];
  assign funct3_d = i_inst_d[14:12];

  main_decoder u_main_decoder (
    .i_opcode         (opcode_d),
    .i_funct3         (funct3_d),
    .i_funct12        (i_inst_d[31:20]),
    .o_reg_write      (reg_write_d),
    .o_mem_req        (mem_req_d),
    .o_mem_write      (mem_write_d),
    .o_alu_src        (alu_src_d),
    .o_imm_plus_src   (imm_plus_src_d),
    .o_is_load_signed (is_load_signed_d),
    .o_branch         (branch_d),
    .o_jal            (o_jal_d),
    .o_jalr           (jalr_d),
    .o_ecall          (o_ecall_d),
    .o_result_src     (result_src_d),
    .o_imm_src        (o_imm_src_d),
    .o_alu_op         (alu_op_d)
  );

  alu_decoder u_alu_decoder (
    .i_alu_op    (alu_op_d),
    .i_funct3    (funct3_d),
    .i_opcode_b5 (opcode_d[5]),
    .i_funct7_b5 (i_inst_d[30]),
    .o_alu_ctrl  (alu_dec_ctrl_d),
    .o_mem_size  (mem_size_d)
  );

  // lui just passes the immediate through
  assign alu_ctrl_d = (opcode_d == OP_LUI) ? ALU_PASSB : alu_dec_ctrl_d;

  // id/ex controls, clear makes a bubble
  always_ff @(posedge clk) begin
    if (i_rst || i_id_ex_clear) begin
      o_alu_ctrl_e     <= ALU_ADD;
      o_alu_src_e      <= 1'b0;
      o_imm_plus_src_e <= 1'b0;
      o_result_src_e   <= RES_ALU;
      reg_write_e      <= 1'b0;
      mem_req_e        <= 1'b0;
      mem_write_e      <= 1'b0;
      mem_size_e       <= SIZE_B;
      is_load_signed_e <= 1'b0;
      branch_e         <= 1'b0;
      jalr_e           <= 1'b0;
      ecall_e          <= 1'b0;
    end else begin
      o_alu_ctrl_e     <= alu_ctrl_d;
      o_alu_src_e      <= alu_src_d;
      o_imm_plus_src_e <= imm_plus_src_d;
      o_result_src_e   <= result_src_d;
      reg_write_e      <= reg_write_d;
      mem_req_e        <= mem_req_d;
      mem_write_e      <= mem_write_d;
      mem_size_e       <= mem_size_d;
      is_load_signed_e <= is_load_signed_d;
      branch_e         <= branch_d;
      jalr_e           <= jalr_d;
      ecall_e          <= o_ecall_d;
    end
  end

  // register numbers and funct3, meaningless in a bubble
  always_ff @(posedge clk) begin
    if (!i_id_ex_clear) begin
      funct3_e <= funct3_d;
      o_rd_e   <= i_inst_d[11:7];
      o_rs1_e  <= i_inst_d[19:15];
      o_rs2_e  <= i_inst_d[24:20];
    end
  end

  branch_resolver u_branch_resolver (
    .i_branch (branch_e),
    .i_jalr   (jalr_e),
    .i_ecall  (ecall_e),
    .i_zero   (i_zero_e),
    .i_neg    (i_neg_e),
    .i_negu   (i_negu_e),
    .i_funct3 (funct3_e),
    .o_pc_src (o_pc_src_e)
  );

  // ex/mem
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_mem_req_m        <= 1'b0;
      o_mem_write_m      <= 1'b0;
      o_mem_size_m       <= SIZE_B;
      o_is_load_signed_m <= 1'b0;
      o_result_src_m     <= RES_ALU;
      o_reg_write_m      <= 1'b0;
    end else begin
      o_mem_req_m        <= mem_req_e;
      o_mem_write_m      <= mem_write_e;
      o_mem_size_m       <= mem_size_e;
      o_is_load_signed_m <= is_load_signed_e;
      o_result_src_m     <= o_result_src_e;
      o_reg_write_m      <= reg_write_e;
    end
  end

  // mem/wb
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_result_src_w <= RES_ALU;
      o_reg_write_w  <= 1'b0;
    end else begin
      o_result_src_w <= o_result_src_m;
      o_reg_write_w  <= o_reg_write_m;
    end
  end

  always_ff @(posedge clk) begin
    o_rd_m <= o_rd_e;
    o_rd_w <= o_rd_m;
  end

endmodule

// File: hw/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver import rv_ctrl_pkg::*; (
  input  logic       i_branch,
  input  logic       i_jalr,
  input  logic       i_ecall,
  input  logic       i_zero,
  input  logic       i_neg,
  input  logic       i_negu,
  input  logic [2:0] i_funct3,
  output pc_src_t    o_pc_src
);

  logic cond;

  // branch condition from the subtraction flags
  always_comb begin
    case (i_funct3)
      3'b000:  cond = i_zero;
      3'b001:  cond = ~i_zero;
      3'b100:  cond = i_neg;
      3'b101:  cond = ~i_neg;
      3'b110:  cond = i_negu;
      3'b111:  cond = ~i_negu;
      default: cond = 1'b0;
    endcase
  end

  // ecall wins over jalr, jalr over a taken branch
  always_comb begin
    if (i_ecall) begin
      o_pc_src = PC_ECALL;
    end else if (i_jalr) begin
      o_pc_src = PC_JALR;
    end else if (i_branch && cond) begin
      o_pc_src = PC_BRANCH;
    end else begin
      o_pc_src = PC_PLUS4;
    end
  end

endmodule

// File: hw/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder import rv_ctrl_pkg::*; (
  input  alu_op_t    i_alu_op,
  input  logic [2:0] i_funct3,
  input  logic       i_opcode_b5,
  input  logic       i_funct7_b5,
  output alu_ctrl_t  o_alu_ctrl,
  output mem_size_t  o_mem_size
);

  always_comb begin
    case (i_alu_op)
      ALUOP_SUB: o_alu_ctrl = ALU_SUB;
      ALUOP_FUNCT: begin
        case (i_funct3)
          // addi has no sub form, so funct7 only counts for r-type
          3'b000:  o_alu_ctrl = (i_opcode_b5 && i_funct7_b5) ? ALU_SUB : ALU_ADD;
          3'b001:  o_alu_ctrl = ALU_SLL;
          3'b010:  o_alu_ctrl = ALU_SLT;
          3'b011:  o_alu_ctrl = ALU_SLTU;
          3'b100:  o_alu_ctrl = ALU_XOR;
          3'b101:  o_alu_ctrl = i_funct7_b5 ? ALU_SRA : ALU_SRL;
          3'b110:  o_alu_ctrl = ALU_OR;
          default: o_alu_ctrl = ALU_AND;
        endcase
      end
      default: o_alu_ctrl = ALU_ADD;
    endcase
  end

  // access size from funct3[1:0]
  always_comb begin
    case (i_funct3[1:0])
      2'b00:   o_mem_size = SIZE_B;
      2'b01:   o_mem_size = SIZE_H;
      default: o_mem_size = SIZE_W;
    endcase
  end

endmodule

// File: hw/main_decoder.sv
`timescale 1ns/1ps

module main_decoder import rv_ctrl_pkg::*; (
  input  logic [6:0]  i_opcode,
  input  logic [2:0]  i_funct3,
  input  logic [11:0] i_funct12,
  output logic        o_reg_write,
  output logic        o_mem_req,
  output logic        o_mem_write,
  output logic        o_alu_src,
  output logic        o_imm_plus_src,
  output logic        o_is_load_signed,
  output logic        o_branch,
  output logic        o_jal,
  output logic        o_jalr,
  output logic        o_ecall,
  output result_src_t o_result_src,
  output imm_src_t    o_imm_src,
  output alu_op_t     o_alu_op
);

  // lb/lh sign extend, lbu/lhu do not
  assign o_is_load_signed = ~i_funct3[2];

  always_comb begin
    // bubble unless the opcode says otherwise
    o_reg_write    = 1'b0;
    o_mem_req      = 1'b0;
    o_mem_write    = 1'b0;
    o_alu_src      = 1'b0;
    o_imm_plus_src = 1'b0;
    o_branch       = 1'b0;
    o_jal          = 1'b0;
    o_jalr         = 1'b0;
    o_ecall        = 1'b0;
    o_result_src   = RES_ALU;
    o_imm_src      = IMM_I;
    o_alu_op       = ALUOP_ADD;
    case (i_opcode)
      OP_OP: begin
        o_reg_write = 1'b1;
        o_alu_op    = ALUOP_FUNCT;
      end
      OP_OPIMM: begin
        o_reg_write = 1'b1;
        o_alu_src   = 1'b1;
        o_alu_op    = ALUOP_FUNCT;
      end
      OP_LOAD: begin
        o_reg_write  = 1'b1;
        o_mem_req    = 1'b1;
        o_alu_src    = 1'b1;
        o_result_src = RES_MEM;
      end
      OP_STORE: begin
        o_mem_req   = 1'b1;
        o_mem_write = 1'b1;
        o_alu_src   = 1'b1;
        o_imm_src   = IMM_S;
      end
      OP_BRANCH: begin
        // compare by subtraction, flags come back from execute
        o_branch  = 1'b1;
        o_imm_src = IMM_B;
        o_alu_op  = ALUOP_SUB;
      end
      OP_JAL: begin
        // target is pc + imm, redirected from decode
        o_reg_write  = 1'b1;
        o_jal        = 1'b1;
        o_result_src = RES_PC4;
        o_imm_src    = IMM_J;
      end
      OP_JALR: begin
        o_reg_write    = 1'b1;
        o_jalr         = 1'b1;
        o_alu_src      = 1'b1;
        o_imm_plus_src = 1'b1;
        o_result_src   = RES_PC4;
      end
      OP_LUI: begin
        o_reg_write = 1'b1;
        o_alu_src   = 1'b1;
        o_imm_src   = IMM_U;
      end
      OP_AUIPC: begin
        o_reg_write    = 1'b1;
        o_alu_src      = 1'b1;
        o_imm_plus_src = 1'b1;
        o_imm_src      = IMM_U;
      end
      OP_SYSTEM: begin
        // only ecall is handled, as a pc redirect
        o_ecall = (i_funct12 == 12'h000);
      end
      default: begin
      end
    endcase
  end

endmodule

// File: hw/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  // rv32i major opcodes
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_OPIMM  = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // alu operation seen by the datapath
  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLL   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_SLT   = 4'd8,
    ALU_SLTU  = 4'd9,
    ALU_PASSB = 4'd10
  } alu_ctrl_t;

  // class from main decoder to alu decoder
  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'd0,
    ALUOP_SUB   = 2'd1,
    ALUOP_FUNCT = 2'd2
  } alu_op_t;

  // writeback source
  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2
  } result_src_t;

  // next pc source, resolved in execute
  typedef enum logic [1:0] {
    PC_PLUS4  = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JALR   = 2'd2,
    PC_ECALL  = 2'd3
  } pc_src_t;

  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_src_t;

  // operand forwarding select
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_WB   = 2'd1,
    FWD_MEM  = 2'd2
  } fwd_t;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } mem_size_t;

endpackage
